// File: Bender.yml
package:
  name: pit_timer

sources:
  - logic/pit_pkg.sv
  - logic/pit_bus_decode.sv
  - logic/pit_down_counter.sv
  - logic/pit_counter_unit.sv
  - logic/pit_timer.sv
  - target: test
    files:
      - bench/pit_timer_checker.sv
      - bench/pit_timer_tb.sv

// File: bench/pit_timer_checker.sv
// bound into pit_timer, rules hold only with ce qualifying the bus; failures also counted
`default_nettype none

module pit_timer_checker (
	input logic                            clk,
	input logic                            rst,
	input logic                            ce,
	input logic                            tce,
	input logic [1:0]                      a,
	input logic                            wr,
	input logic                            rd,
	input logic [7:0]                      dout,
	input logic [pit_pkg::PIT_NUM_CH-1:0] out
);
	import pit_pkg::*;

	int   assert_fails = 0;	// read by the testbench at the end
	logic ctrl_wr;

	assign ctrl_wr = ce & wr & (a == PIT_CTRL_ADDR);

	// ----------------------------------------------------------
	// bus and output rules
	// ----------------------------------------------------------

	// read mux idles at zero
	dout_idle: assert property (@(posedge clk) disable iff (rst)
		!(ce && rd) |=> (dout == 8'h00))
	else begin
		$error("dout nonzero after a cycle without a read");
		assert_fails++;
	end

	out_after_reset: assert property (@(posedge clk) rst |=> (out == '0))
	else begin
		$error("out nonzero in the cycle after reset");
		assert_fails++;
	end

	// only a tce or a control word moves out
	out_hold: assert property (@(posedge clk) disable iff (rst)
		(!tce && !ctrl_wr) |=> $stable(out))
	else begin
		$error("out changed without tce or a control write");
		assert_fails++;
	end

endmodule

bind pit_timer pit_timer_checker i_checker (
	.clk  (clk),
	.rst  (rst),
	.ce   (ce),
	.tce  (tce),
	.a    (a),
	.wr   (wr),
	.rd   (rd),
	.dout (dout),
	.out  (out)
);

`default_nettype wire

// File: bench/pit_timer_tb.sv
// reads bench/pit_timer_vectors.txt from the project root; ce held high, tce pulsed only here
`default_nettype none

module pit_timer_tb;
	import pit_pkg::*;

	localparam int MAX_STEPS    = 32;
	localparam int COLS         = 7;	// op ch mode rw count arg expect
	localparam int EDGE_TIMEOUT = 64;	// tce pulses
	localparam int DRIVE_DLY    = 2;

	logic                  clk = 1'b0;
	logic                  rst = 1'b1;
	logic                  ce  = 1'b1;
	logic                  tce = 1'b0;
	logic [1:0]            a   = 2'd0;
	logic                  wr  = 1'b0;
	logic                  rd  = 1'b0;
	logic [7:0]            din = 8'h00;
	logic [7:0]            dout;
	logic [PIT_NUM_CH-1:0] out;

	logic [31:0] vec_mem [0:MAX_STEPS*COLS-1];
	logic [31:0] lcg_state;
	int          errors = 0;

	// model state per channel with p counting tce pulses since programming
	logic [2:0] ch_mode [PIT_NUM_CH];
	int         ch_n [PIT_NUM_CH];
	int         ch_p [PIT_NUM_CH];
	logic       ch_on [PIT_NUM_CH];

	pit_timer i_dut (
		.clk  (clk),
		.rst  (rst),
		.ce   (ce),
		.tce  (tce),
		.a    (a),
		.wr   (wr),
		.rd   (rd),
		.din  (din),
		.dout (dout),
		.out  (out)
	);

	always #20 clk = ~clk;	// period 40

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// out level after pulse p where pulse 1 transfers the count
	function automatic logic expected_out(input logic [2:0] mode, input int n, input int p);
		if (p == 0)
			return mode != PIT_MODE0;	// level set by the control word
		case (mode)
			PIT_MODE0: return p >= n + 1;	// rises at N+1, stays
			PIT_MODE2: return (p % n) != 0;	// one low pulse per period
			PIT_MODE3: return ((p - 1) % n) < (n + 1) / 2;	// high half gets the odd pulse
			PIT_MODE4: return p != n + 1;	// single strobe
			default:   return 1'b1;
		endcase
	endfunction

	function automatic string op_name(input logic [31:0] op);
		case (op)
			1: return "latch read";
			2: return "program";
			3: return "run";
			4: return "wait edge";
			5: return "control word";
			default: return "unknown";
		endcase
	endfunction

	// ----------------------------------------------------------
	// bus and tce drivers
	// ----------------------------------------------------------

	task automatic idle_gap();
		logic [31:0] r;
		r = lcg_next();
		repeat (r[17:16]) @(posedge clk);	// 0..3 idle cycles
	endtask

	task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
		@(posedge clk);
		#DRIVE_DLY;
		a   = addr;
		din = data;
		wr  = 1'b1;
		@(posedge clk);
		#DRIVE_DLY wr = 1'b0;
		idle_gap();
	endtask

	task automatic bus_read(input logic [1:0] addr, output logic [7:0] data);
		@(posedge clk);
		#DRIVE_DLY;
		a  = addr;
		rd = 1'b1;
		@(posedge clk);
		#DRIVE_DLY rd = 1'b0;
		data = dout;	// registered rdata is valid from this edge
		idle_gap();
	endtask

	// one tce pulse, then every programmed channel is checked
	task automatic pulse_tce();
		logic exp_lvl;
		int   i;
		@(posedge clk);
		#DRIVE_DLY tce = 1'b1;
		@(posedge clk);
		#DRIVE_DLY tce = 1'b0;
		for (i = 0; i < PIT_NUM_CH; i++) begin
			if (ch_on[i]) begin
				ch_p[i]++;
				exp_lvl = expected_out(ch_mode[i], ch_n[i], ch_p[i]);
				assert (out[i] == exp_lvl) else begin
					$display("Error %0t: ch%0d out %b after tce pulse %0d, expected %b",
						$time, i, out[i], ch_p[i], exp_lvl);
					errors++;
				end
			end
		end
	endtask

	task automatic program_channel(input int ch, input logic [2:0] mode, input logic [1:0] rw,
		input logic [15:0] n);
		bus_write(PIT_CTRL_ADDR, {ch[1:0], rw, mode, 1'b0});
		if (rw != PIT_RW_MSB)
			bus_write(ch[1:0], n[7:0]);
		if (rw != PIT_RW_LSB)
			bus_write(ch[1:0], n[15:8]);	// msb last ends the load
		ch_mode[ch] = mode;
		ch_n[ch]    = n;
		ch_p[ch]    = 0;
		ch_on[ch]   = 1'b1;
		assert (out[ch] == expected_out(mode, n, 0)) else begin
			$display("Error %0t: ch%0d out %b after control word", $time, ch, out[ch]);
			errors++;
		end
	endtask

	// ----------------------------------------------------------
	// test steps
	// ----------------------------------------------------------

	task automatic latch_read(input int ch, input logic [1:0] rw, input int k,
		input logic [15:0] exp_val);
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [15:0] got;
		pulse_tce();	// count transfer
		repeat (k) pulse_tce();
		bus_write(PIT_CTRL_ADDR, {ch[1:0], 6'b000000});
		repeat (2) pulse_tce();	// count moves on, latch must not
		bus_write(PIT_CTRL_ADDR, {ch[1:0], 6'b000000});
		lo = 8'h00;
		hi = 8'h00;
		case (rw)
			PIT_RW_LSB_MSB: begin
				bus_read(ch[1:0], lo);
				bus_read(ch[1:0], hi);
				got = {hi, lo};
			end
			PIT_RW_MSB: begin
				bus_read(ch[1:0], hi);
				got = {8'h00, hi};
			end
			default: begin
				bus_read(ch[1:0], lo);
				got = {8'h00, lo};
			end
		endcase
		assert (got == exp_val) else begin
			$display("Error %0t: ch%0d latched read %h, expected %h", $time, ch, got, exp_val);
			errors++;
		end
	endtask

	task automatic wait_out_edge(input int ch, input int exp_pulse);
		logic lvl;
		bit   seen;
		int   i;
		lvl  = out[ch];
		seen = 1'b0;
		for (i = 0; i < EDGE_TIMEOUT && !seen; i++) begin
			pulse_tce();
			if (out[ch] != lvl)
				seen = 1'b1;
		end
		if (!seen) begin
			$display("channel %0d output failed to toggle within %0d tce pulses",
				ch, EDGE_TIMEOUT);
			errors++;
		end else begin
			assert (ch_p[ch] == exp_pulse) else begin
				$display("Error %0t: ch%0d out toggled at pulse %0d, expected %0d",
					$time, ch, ch_p[ch], exp_pulse);
				errors++;
			end
		end
	endtask

	task automatic control_only(input int ch, input logic [2:0] mode, input logic [1:0] rw,
		input logic exp_lvl);
		logic exp_i;
		int   i;
		bus_write(PIT_CTRL_ADDR, {ch[1:0], rw, mode, 1'b0});
		if (ch >= PIT_NUM_CH) begin
			// field 3 reaches no channel so running ones keep their model level
			for (i = 0; i < PIT_NUM_CH; i++) begin
				if (ch_on[i]) begin
					exp_i = expected_out(ch_mode[i], ch_n[i], ch_p[i]);
					assert (out[i] == exp_i) else begin
						$display("Error %0t: ch%0d out %b after channel field 3, expected %b",
							$time, i, out[i], exp_i);
						errors++;
					end
				end
			end
		end else begin
			ch_on[ch] = 1'b0;	// disarmed until loaded again
			assert (out[ch] == exp_lvl) else begin
				$display("Error %0t: ch%0d out %b after control word, expected %b",
					$time, ch, out[ch], exp_lvl);
				errors++;
			end
		end
	endtask

	initial begin
		int          step;
		int          base;
		int          err_before;
		int          steps_run;
		int          steps_failed;
		bit          done;
		logic [31:0] op;
		int          ch;
		steps_run    = 0;
		steps_failed = 0;
		done         = 1'b0;
		lcg_state    = 32'd32;
		for (int i = 0; i < PIT_NUM_CH; i++)
			ch_on[i] = 1'b0;
		$readmemh("bench/pit_timer_vectors.txt", vec_mem);

		repeat (3) @(posedge clk);
		#DRIVE_DLY rst = 1'b0;
		assert (out == '0 && dout == 8'h00) else begin
			$display("Error %0t: out %b dout %h after reset", $time, out, dout);
			errors++;
		end
		$display("reset %s", (errors == 0) ? "ok" : "failed");

		for (step = 0; step < MAX_STEPS && !done; step++) begin
			base = step * COLS;
			op   = vec_mem[base];
			ch   = int'(vec_mem[base + 1]);
			if ($isunknown(op)) begin
				if (step == 0) begin
					$display("vector file bench/pit_timer_vectors.txt could not be read");
					errors++;
				end
				done = 1'b1;
			end else if (op == 0) begin
				done = 1'b1;	// end marker
			end else begin
				err_before = errors;
				case (op)
					1: begin
						program_channel(ch, vec_mem[base + 2][2:0], vec_mem[base + 3][1:0],
							vec_mem[base + 4][15:0]);
						latch_read(ch, vec_mem[base + 3][1:0], int'(vec_mem[base + 5]),
							vec_mem[base + 6][15:0]);
					end
					2: program_channel(ch, vec_mem[base + 2][2:0], vec_mem[base + 3][1:0],
						vec_mem[base + 4][15:0]);
					3: repeat (int'(vec_mem[base + 5])) pulse_tce();
					4: wait_out_edge(ch, int'(vec_mem[base + 6]));
					5: control_only(ch, vec_mem[base + 2][2:0], vec_mem[base + 3][1:0],
						vec_mem[base + 6][0]);
					default: begin
						$display("step %0d has an unknown operation code %0h", step, op);
						errors++;
					end
				endcase
				steps_run++;
				if (errors != err_before)
					steps_failed++;
				$display("step %0d %s ch%0d %s", step, op_name(op), ch,
					(errors == err_before) ? "ok" : "failed");
			end
		end

		repeat (2) @(posedge clk);
		errors += i_dut.i_checker.assert_fails;	// bound assertion failures
		$display("steps %0d, failed %0d, errors %0d", steps_run, steps_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/pit_timer_vectors.txt
// op ch mode rw count arg expect, all hex, one step per line
// op 1 latch read, 2 program, 3 run arg tce pulses, 4 wait for out edge, 5 control word, 0 end
1 0 0 3 1234 5 122f
1 1 0 1 00a7 3 00a4
1 2 0 2 1200 2 0011
2 0 0 3 000a 0 0
4 0 0 0 0000 0 000b
3 0 0 0 0000 4 0
5 0 0 3 0000 0 0000
2 1 2 3 0004 0 0
3 1 0 0 0000 d 0
2 2 3 3 0006 0 0
3 2 0 0 0000 13 0
2 2 3 3 0007 0 0
4 2 0 0 0000 0 0005
3 2 0 0 0000 10 0
2 0 4 3 0009 0 0
4 0 0 0 0000 0 000a
3 0 0 0 0000 5 0
2 0 3 3 0005 0 0
2 1 2 3 0003 0 0
2 2 0 3 0008 0 0
3 0 0 0 0000 c 0
5 3 0 3 0000 0 0
5 3 0 0 0000 0 0
3 0 0 0 0000 a 0
0 0 0 0 0000 0 0

// File: logic/pit_bus_decode.sv
// bus strobes qualified by ce here only; wr and rd must not both be high in one ce cycle
`default_nettype none

module pit_bus_decode (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            ce,	// bus clock enable
	input  logic [1:0]                      a,
	input  logic                            wr,
	input  logic                            rd,
	input  logic [7:0]                      din,
	input  logic [7:0]                      rdata0,
	input  logic [7:0]                      rdata1,
	input  logic [7:0]                      rdata2,
	output logic [pit_pkg::PIT_NUM_CH-1:0] data_wr,
	output logic [pit_pkg::PIT_NUM_CH-1:0] cw_set,
	output logic [pit_pkg::PIT_NUM_CH-1:0] latch_cmd,
	output logic [pit_pkg::PIT_NUM_CH-1:0] rd_sel,
	output logic [7:0]                      dout
);
	import pit_pkg::*;

	logic                  bus_wr;
	logic                  bus_rd;
	logic                  ctrl_wr;
	logic                  is_latch;	// format field zero
	logic [PIT_NUM_CH-1:0] rd_sel_q;	// unit read last cycle

	assign bus_wr   = ce & wr;
	assign bus_rd   = ce & rd;
	assign ctrl_wr  = bus_wr & (a == PIT_CTRL_ADDR);
	assign is_latch = (din[5:4] == PIT_RW_LATCH);

	// one-hot strobes per channel
	always_comb begin
		for (int i = 0; i < PIT_NUM_CH; i++) begin
			data_wr[i]   = bus_wr & (a == 2'(i));
			rd_sel[i]    = bus_rd & (a == 2'(i));
			cw_set[i]    = ctrl_wr & (din[7:6] == 2'(i)) & ~is_latch;	// field 3 never matches
			latch_cmd[i] = ctrl_wr & (din[7:6] == 2'(i)) & is_latch;
		end
	end

	// remember which unit was read, its rdata is valid one cycle later
	always_ff @(posedge clk) begin
		if (rst)
			rd_sel_q <= '0;
		else
			rd_sel_q <= rd_sel;
	end

	// read mux, 0 when nothing was read
	always_comb begin
		case (rd_sel_q)
			3'b001:  dout = rdata0;
			3'b010:  dout = rdata1;
			3'b100:  dout = rdata2;
			default: dout = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/pit_counter_unit.sv
// one channel, modes 0/2/3/4 only, no gate input, mode 3 needs a count of 2 or more
`default_nettype none

module pit_counter_unit (
	input  logic       clk,
	input  logic       rst,
	input  logic       tce,		// timer clock enable
	input  logic [7:0] din,		// load byte or control word
	input  logic       cw_set,		// control word for this channel
	input  logic       latch_cmd,	// counter latch command
	input  logic       data_wr,		// count byte write
	input  logic       rd_sel,		// count byte read
	output logic [7:0] rdata,
	output logic       out
);
	import pit_pkg::*;

	pit_mode_e  mode;
	pit_mode_e  cw_mode;		// mode field of din
	pit_rw_e    rw;
	pit_count_t load_value;		// assembled count
	pit_count_t latch_value;	// frozen count for reads
	pit_count_t count;
	pit_count_t read_src;
	logic       out_reg;
	logic       load_msb;		// two-byte load, msb comes next
	logic       starting;		// count written, waiting for tce
	logic       armed;
	logic       latched;
	logic       read_msb;		// two-byte read, msb comes next
	logic       mode_ok;
	logic       stop_on_wr;
	logic       m3_last;
	logic       reload;
	logic       load_en;
	logic       count_en;
	logic       half_mode;

	// codes 6 and 7 alias to modes 2 and 3
	assign cw_mode = pit_mode_e'({din[3] & ~din[2], din[2:1]});

	// ----------------------------------------------------------
	// mode decode and counter control
	// ----------------------------------------------------------

	assign mode_ok    = (mode == PIT_MODE0) || (mode == PIT_MODE2) ||
	                    (mode == PIT_MODE3) || (mode == PIT_MODE4);	// 1 and 5 never start
	assign stop_on_wr = (mode == PIT_MODE0) || (mode == PIT_MODE4);
	assign half_mode  = (mode == PIT_MODE3);

	// last tce of a square wave half period
	// odd counts step by 3 while low, so 3 is terminal too
	assign m3_last = (count == 16'd2) || ((count == 16'd3) && !out_reg);

	assign reload   = armed & (((mode == PIT_MODE2) && (count == 16'd1)) ||
	                           (half_mode && m3_last));
	assign load_en  = tce & ((starting & mode_ok) | reload);
	assign count_en = tce & armed;

	assign read_src = latched ? latch_value : count;
	assign out      = out_reg;

	pit_down_counter u_ctr (
		.clk        (clk),
		.rst        (rst),
		.count_en   (count_en),
		.half_mode  (half_mode),
		.out_level  (out_reg),
		.load_en    (load_en),
		.load_value (load_value),
		.count      (count)
	);

	// ----------------------------------------------------------
	// control state
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			mode     <= PIT_MODE0;
			rw       <= PIT_RW_LSB_MSB;
			out_reg  <= 1'b0;
			load_msb <= 1'b0;
			starting <= 1'b0;
			armed    <= 1'b0;
			latched  <= 1'b0;
			read_msb <= 1'b0;
		end else begin
			// timer side first, bus writes below win on a clash
			if (tce) begin
				if (starting && mode_ok) begin
					armed    <= 1'b1;	// count transferred on this tce
					starting <= 1'b0;
				end
				case (mode)
					PIT_MODE0: if (armed && count == 16'd1) begin
						out_reg <= 1'b1;	// terminal count, stays high
						armed   <= 1'b0;
					end
					PIT_MODE2: if (armed) begin
						if (count == 16'd2)
							out_reg <= 1'b0;	// low while count is 1
						else if (count == 16'd1)
							out_reg <= 1'b1;
					end
					PIT_MODE3: if (armed && m3_last)
						out_reg <= ~out_reg;
					PIT_MODE4: if (armed && count == 16'd1) begin
						out_reg <= 1'b0;	// strobe, one tce wide
						armed   <= 1'b0;
					end else begin
						out_reg <= 1'b1;
					end
					default: ;
				endcase
			end

			if (cw_set) begin
				mode     <= cw_mode;
				rw       <= pit_rw_e'(din[5:4]);
				out_reg  <= (cw_mode != PIT_MODE0);	// low only in mode 0
				armed    <= 1'b0;
				starting <= 1'b0;
				load_msb <= 1'b0;
				latched  <= 1'b0;
				read_msb <= 1'b0;
			end

			if (latch_cmd)
				latched <= 1'b1;	// a second latch keeps the first value

			if (data_wr) begin
				if (stop_on_wr)
					armed <= 1'b0;	// modes 0/4 hold until new count is in
				case (rw)
					PIT_RW_LSB, PIT_RW_MSB: starting <= 1'b1;
					PIT_RW_LSB_MSB: begin
						load_msb <= ~load_msb;
						if (load_msb)
							starting <= 1'b1;
						else if (stop_on_wr)
							starting <= 1'b0;
					end
					default: ;
				endcase
			end

			if (rd_sel) begin
				if (rw == PIT_RW_LSB_MSB)
					read_msb <= ~read_msb;
				if (rw != PIT_RW_LSB_MSB || read_msb)
					latched <= 1'b0;	// last byte of the latch read out
			end
		end
	end

	// ----------------------------------------------------------
	// load bytes, latch and read data
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (data_wr) begin
			case (rw)
				PIT_RW_LSB: load_value <= {8'h00, din};	// other byte cleared
				PIT_RW_MSB: load_value <= {din, 8'h00};
				PIT_RW_LSB_MSB: begin
					if (load_msb)
						load_value[15:8] <= din;
					else
						load_value[7:0] <= din;
				end
				default: ;
			endcase
		end
		if (latch_cmd && !latched)
			latch_value <= count;
		if (rd_sel) begin
			case (rw)
				PIT_RW_MSB:     rdata <= read_src[15:8];
				PIT_RW_LSB_MSB: rdata <= read_msb ? read_src[15:8] : read_src[7:0];
				default:        rdata <= read_src[7:0];
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/pit_down_counter.sv
// binary down counter only, wraps 0 to 65535; half mode expects out_level to track the channel
`default_nettype none

module pit_down_counter (
	input  logic                clk,
	input  logic                rst,
	input  logic                count_en,	// tce while armed
	input  logic                half_mode,	// mode 3 stepping
	input  logic                out_level,	// channel out, picks odd step
	input  logic                load_en,
	input  pit_pkg::pit_count_t load_value,
	output pit_pkg::pit_count_t count
);
	import pit_pkg::*;

	pit_count_t step;

	// ----------------------------------------------------------
	// step size
	// ----------------------------------------------------------

	// odd square wave periods: high half gets the extra tce
	always_comb begin
		if (!half_mode)
			step = 16'd1;
		else if (!count[0])
			step = 16'd2;
		else if (out_level)
			step = 16'd1;	// odd, high half, drop to even
		else
			step = 16'd3;	// odd, low half, one tce short
	end

	// load wins over counting
	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (load_en)
			count <= load_value;
		else if (count_en)
			count <= count - step;
	end

endmodule

`default_nettype wire

// File: logic/pit_pkg.sv
// binary counting only; control word bit 0 (bcd) is ignored, channel field 3 selects nothing
`default_nettype none

package pit_pkg;

	// ----------------------------------------------------------
	// control word fields
	// ----------------------------------------------------------

	// counter mode, control word bits 3..1
	typedef enum logic [2:0] {
		PIT_MODE0 = 3'd0,	// interrupt on terminal count
		PIT_MODE1 = 3'd1,	// hw one-shot, not built
		PIT_MODE2 = 3'd2,	// rate generator
		PIT_MODE3 = 3'd3,	// square wave
		PIT_MODE4 = 3'd4,	// software strobe
		PIT_MODE5 = 3'd5	// hw strobe, not built
	} pit_mode_e;

	// read/load format, control word bits 5..4
	typedef enum logic [1:0] {
		PIT_RW_LATCH   = 2'd0,	// counter latch command
		PIT_RW_LSB     = 2'd1,
		PIT_RW_MSB     = 2'd2,
		PIT_RW_LSB_MSB = 2'd3	// lsb first, then msb
	} pit_rw_e;

	// ----------------------------------------------------------
	// counter and bus
	// ----------------------------------------------------------

	// one count value, 0 stands for 65536
	typedef logic [15:0] pit_count_t;

	localparam int PIT_NUM_CH = 3;	// counter channels

	// a == 3 is the control register, 0..2 reach the counters
	localparam logic [1:0] PIT_CTRL_ADDR = 2'd3;

endpackage

`default_nettype wire

// File: logic/pit_timer.sv
// 8253-style timer top, gate inputs, bcd, modes 1/5 and read-back are not built
`default_nettype none

module pit_timer (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            ce,	// bus clock enable
	input  logic                            tce,	// timer clock enable, all channels
	input  logic [1:0]                      a,
	input  logic                            wr,
	input  logic                            rd,
	input  logic [7:0]                      din,
	output logic [7:0]                      dout,
	output logic [pit_pkg::PIT_NUM_CH-1:0] out
);
	import pit_pkg::*;

	logic [PIT_NUM_CH-1:0] data_wr;
	logic [PIT_NUM_CH-1:0] cw_set;
	logic [PIT_NUM_CH-1:0] latch_cmd;
	logic [PIT_NUM_CH-1:0] rd_sel;
	logic [7:0]            rdata0;
	logic [7:0]            rdata1;
	logic [7:0]            rdata2;

	// ----------------------------------------------------------
	// bus side
	// ----------------------------------------------------------

	pit_bus_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.a         (a),
		.wr        (wr),
		.rd        (rd),
		.din       (din),
		.rdata0    (rdata0),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.data_wr   (data_wr),
		.cw_set    (cw_set),
		.latch_cmd (latch_cmd),
		.rd_sel    (rd_sel),
		.dout      (dout)
	);

	// ----------------------------------------------------------
	// channels, din doubles as control word
	// ----------------------------------------------------------

	pit_counter_unit u_ch0 (
		.clk (clk), .rst (rst), .tce (tce), .din (din),
		.cw_set    (cw_set[0]),
		.latch_cmd (latch_cmd[0]),
		.data_wr   (data_wr[0]),
		.rd_sel    (rd_sel[0]),
		.rdata     (rdata0),
		.out       (out[0])
	);

	pit_counter_unit u_ch1 (
		.clk (clk), .rst (rst), .tce (tce), .din (din),
		.cw_set    (cw_set[1]),
		.latch_cmd (latch_cmd[1]),
		.data_wr   (data_wr[1]),
		.rd_sel    (rd_sel[1]),
		.rdata     (rdata1),
		.out       (out[1])
	);

	pit_counter_unit u_ch2 (
		.clk (clk), .rst (rst), .tce (tce), .din (din),
		.cw_set    (cw_set[2]),
		.latch_cmd (latch_cmd[2]),
		.data_wr   (data_wr[2]),
		.rd_sel    (rd_sel[2]),
		.rdata     (rdata2),
		.out       (out[2])
	);

endmodule

`default_nettype wire

// File: pit_timer.f
logic/pit_pkg.sv
logic/pit_bus_decode.sv
logic/pit_down_counter.sv
logic/pit_counter_unit.sv
logic/pit_timer.sv
bench/pit_timer_checker.sv
bench/pit_timer_tb.sv
